// ==== hw/manycore_addr_pkg.sv ====
//**********************************************************
// address map package for the remote request path
//  - map and credit constants, derived widths
//  - EVA class prefixes
//  - vector typedefs for addresses, coordinates, hash fields
//**********************************************************

package manycore_addr_pkg;

  // base map constants
  localparam int num_tiles_x_gp        = 4;       // columns
  localparam int vcache_block_words_gp = 8;       // words per vcache block
  localparam int lg_vcache_size_gp     = 10;      // block-mem words per vcache, log2
  localparam int y_max_gp              = 15;      // bottom vcache row
  localparam logic [15:0] dmem_start_addr_gp = 16'h1000; // word addr of dmem[0]
  localparam int max_out_credits_gp    = 4;       // outstanding request limit

  // derived widths
  localparam int num_vcache_banks_gp         = 2 * num_tiles_x_gp; // top and bottom rows
  localparam int lg_num_tiles_x_gp           = $clog2(num_tiles_x_gp);
  localparam int lg_vcache_banks_gp          = $clog2(num_vcache_banks_gp);
  localparam int vcache_word_offset_width_gp = $clog2(vcache_block_words_gp);
  localparam int credit_width_gp             = $clog2(max_out_credits_gp + 1);

  // dram block number sits above byte and word offset, below bit 31
  localparam int hash_in_width_gp = 31 - 2 - vcache_word_offset_width_gp;

  // class prefixes, checked top down
  localparam logic [1:0] global_prefix_gp = 2'b01;    // eva[31:30]
  localparam logic [2:0] tg_prefix_gp     = 3'b001;   // eva[31:29]
  localparam logic [4:0] shared_prefix_gp = 5'b00001; // eva[31:27]

  // request side
  typedef logic [31:0] eva_t;   // byte address
  typedef logic [31:0] data_t;  // store data

  // network physical address
  typedef logic [3:0]  x_cord_t;
  typedef logic [3:0]  y_cord_t;
  typedef logic [15:0] epa_t;   // word address at the endpoint

  // dram striping
  typedef logic [hash_in_width_gp-1:0]   hash_in_t;  // eva[30:5]
  typedef logic [lg_vcache_banks_gp-1:0] bank_t;     // {bot_not_top, x}
  typedef logic [11:0]                   set_idx_t;

  // remaining credits, 0..max
  typedef logic [credit_width_gp-1:0] credit_t;

endpackage

// ==== hw/dram_hash.sv ====
//**********************************************************
// dram_hash
//  - folds a dram block number into one of eight vcache banks
//  - picks the vcache set index out of the block number
//**********************************************************

`timescale 1ns/1ps

module dram_hash (
  input  manycore_addr_pkg::hash_in_t block_i,   // eva[30:5]
  output manycore_addr_pkg::bank_t    bank_o,    // {bot_not_top, x}
  output manycore_addr_pkg::set_idx_t set_idx_o  // set inside that bank
);

  localparam int bank_w_lp = manycore_addr_pkg::lg_vcache_banks_gp;
  localparam int set_w_lp  = $bits(manycore_addr_pkg::set_idx_t);

  manycore_addr_pkg::bank_t fold_lo; // block bits 2:0
  manycore_addr_pkg::bank_t fold_hi; // block bits 5:3

  assign fold_lo = block_i[0 +: bank_w_lp];
  assign fold_hi = block_i[bank_w_lp +: bank_w_lp];

  // xor fold
  // consecutive blocks walk all banks through fold_lo,
  // a stride of eight blocks still moves through fold_hi
  assign bank_o = fold_lo ^ fold_hi;

  // low bank bits are already spent on the bank, so the set
  // index starts right above them
  assign set_idx_o = block_i[bank_w_lp +: set_w_lp]; // bits 14:3

endmodule

// ==== hw/eva_to_npa.sv ====
//**********************************************************
// eva to npa translation for remote requests
//  - classifies a 32-bit eva as dram, global, tile-group,
//    tile-group-shared or invalid
//  - computes destination x, y and word address per class
//  - dram mode stripes through dram_hash
//**********************************************************

`timescale 1ns/1ps

module eva_to_npa (
  input  manycore_addr_pkg::eva_t    eva_i,           // byte addr
  input  manycore_addr_pkg::x_cord_t tgo_x_i,         // tile-group origin x
  input  manycore_addr_pkg::y_cord_t tgo_y_i,         // tile-group origin y
  input  logic                       dram_enable_i,   // dram mode
  output manycore_addr_pkg::x_cord_t x_cord_o,
  output manycore_addr_pkg::y_cord_t y_cord_o,
  output manycore_addr_pkg::epa_t    epa_o,           // word addr
  output logic                       is_invalid_addr_o
);

  localparam int woff_w_lp = manycore_addr_pkg::vcache_word_offset_width_gp;
  localparam int lg_vc_lp  = manycore_addr_pkg::lg_vcache_size_gp;
  localparam int lg_x_lp   = manycore_addr_pkg::lg_num_tiles_x_gp;
  localparam int bank_w_lp = manycore_addr_pkg::lg_vcache_banks_gp;

  logic is_dram;
  logic is_global;
  logic is_tg;
  logic is_shared;

  manycore_addr_pkg::hash_in_t hash_block;
  manycore_addr_pkg::bank_t    hash_bank;
  manycore_addr_pkg::set_idx_t hash_set;

  manycore_addr_pkg::y_cord_t tg_y;  // origin relative mod 16
  manycore_addr_pkg::x_cord_t tg_x;
  manycore_addr_pkg::y_cord_t sh_y;
  manycore_addr_pkg::x_cord_t sh_x;
  manycore_addr_pkg::epa_t    sh_epa; // offset into dmem

  // class decode by prefix
  assign is_dram   = eva_i[31];
  assign is_global = eva_i[31:30] == manycore_addr_pkg::global_prefix_gp;
  assign is_tg     = eva_i[31:29] == manycore_addr_pkg::tg_prefix_gp;
  assign is_shared = eva_i[31:27] == manycore_addr_pkg::shared_prefix_gp;

  assign is_invalid_addr_o = ~(is_dram | is_global | is_tg | is_shared);

  // block number above the word offset
  assign hash_block = eva_i[2+woff_w_lp +: $bits(manycore_addr_pkg::hash_in_t)];

  dram_hash hash (
    .block_i   (hash_block),
    .bank_o    (hash_bank),
    .set_idx_o (hash_set)
  );

  // tile-group y in 28:24 and x in 23:18
  // only the low 4 bits survive the add
  assign tg_y = eva_i[27:24] + tgo_y_i;
  assign tg_x = eva_i[21:18] + tgo_x_i;

  // shared y and x are 2 bits at the bottom
  // stripe of one word
  assign sh_y   = manycore_addr_pkg::y_cord_t'(eva_i[5:4]) + tgo_y_i;
  assign sh_x   = manycore_addr_pkg::x_cord_t'(eva_i[3:2]) + tgo_x_i;
  assign sh_epa = eva_i[21:6] + manycore_addr_pkg::dmem_start_addr_gp; // field 26:6 cut to 16

  always_comb begin
    x_cord_o = '0;
    y_cord_o = '0;
    epa_o    = '0;
    if (is_dram) begin
      if (dram_enable_i) begin
        // striped over the vcache rows
        x_cord_o = manycore_addr_pkg::x_cord_t'(hash_bank[lg_x_lp-1:0]);
        y_cord_o = hash_bank[bank_w_lp-1]
          ? manycore_addr_pkg::y_cord_t'(manycore_addr_pkg::y_max_gp)
          : '0;
        epa_o = {1'b0, hash_set, eva_i[2 +: woff_w_lp]};
      end else if (eva_i[30]) begin
        // host memory behind y=1
        x_cord_o = '0;
        y_cord_o = manycore_addr_pkg::y_cord_t'(1);
        epa_o    = {1'b1, eva_i[16:2]};
      end else begin
        // vcache as plain block memory
        x_cord_o = manycore_addr_pkg::x_cord_t'(eva_i[2+lg_vc_lp +: lg_x_lp]); // 13:12
        y_cord_o = eva_i[2+lg_vc_lp+lg_x_lp]                                  // bit 14
          ? manycore_addr_pkg::y_cord_t'(manycore_addr_pkg::y_max_gp)
          : '0;
        epa_o = manycore_addr_pkg::epa_t'(eva_i[2 +: lg_vc_lp]);
      end
    end else if (is_global) begin
      y_cord_o = eva_i[27:24]; // field 29:24 cut to 4 bits
      x_cord_o = eva_i[21:18]; // field 23:18 cut to 4 bits
      epa_o    = eva_i[17:2];
    end else if (is_tg) begin
      y_cord_o = tg_y;
      x_cord_o = tg_x;
      epa_o    = eva_i[17:2];
    end else if (is_shared) begin
      y_cord_o = sh_y;
      x_cord_o = sh_x;
      epa_o    = sh_epa;
    end
  end

  // four decodes plus the unmapped top patterns hit each eva once
  always_comb begin
    a_class_onehot: assert final
      ($onehot({is_dram, is_global, is_tg, is_shared,
                eva_i[31:27] inside {5'b00000, 5'b00010, 5'b00011}}))
      else $error("eva_to_npa: class decode of %h not one-hot", eva_i);
  end

endmodule

// ==== hw/remote_req_ctrl.sv ====
//**********************************************************
// remote_req_ctrl
//  - tile-group origin and dram mode registers
//  - packet output register and error pulse
//  - credit counter with stall decode
//  - request and response protocol checks
//**********************************************************

`timescale 1ns/1ps

module remote_req_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // config
  input  logic                       cfg_v_i,
  input  manycore_addr_pkg::x_cord_t cfg_tgo_x_i,
  input  manycore_addr_pkg::y_cord_t cfg_tgo_y_i,
  input  logic                       cfg_dram_en_i,
  // request
  input  logic                       req_v_i,
  input  manycore_addr_pkg::eva_t    req_eva_i,
  input  logic                       req_we_i,
  input  manycore_addr_pkg::data_t   req_data_i,
  // response, one credit back
  input  logic                       resp_v_i,
  // to translator
  output manycore_addr_pkg::eva_t    eva_o,
  output manycore_addr_pkg::x_cord_t tgo_x_o,
  output manycore_addr_pkg::y_cord_t tgo_y_o,
  output logic                       dram_en_o,
  // from translator
  input  manycore_addr_pkg::x_cord_t npa_x_i,
  input  manycore_addr_pkg::y_cord_t npa_y_i,
  input  manycore_addr_pkg::epa_t    npa_epa_i,
  input  logic                       npa_invalid_i,
  // packet
  output logic                       pkt_v_o,
  output manycore_addr_pkg::x_cord_t pkt_x_o,
  output manycore_addr_pkg::y_cord_t pkt_y_o,
  output manycore_addr_pkg::epa_t    pkt_epa_o,
  output logic                       pkt_we_o,
  output manycore_addr_pkg::data_t   pkt_data_o,
  output logic                       err_v_o,
  output logic                       stall_o
);

  localparam manycore_addr_pkg::credit_t max_credits_lp =
    manycore_addr_pkg::credit_t'(manycore_addr_pkg::max_out_credits_gp);

  logic                      issue;    // valid request this cycle
  manycore_addr_pkg::credit_t credit_r; // credits left

  assign eva_o = req_eva_i; // translate straight off the request
  assign issue = req_v_i & ~npa_invalid_i;

  // config registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgo_x_o   <= '0;
      tgo_y_o   <= '0;
      dram_en_o <= 1'b0;
    end else if (cfg_v_i) begin
      tgo_x_o   <= cfg_tgo_x_i;
      tgo_y_o   <= cfg_tgo_y_i;
      dram_en_o <= cfg_dram_en_i;
    end
  end

  // strobes, high for one cycle after the request edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pkt_v_o <= 1'b0;
      err_v_o <= 1'b0;
    end else begin
      pkt_v_o <= issue;
      err_v_o <= req_v_i & npa_invalid_i; // dropped, no packet
    end
  end

  // packet fields, only meaningful under pkt_v_o
  always_ff @(posedge clk_i) begin
    if (issue) begin
      pkt_x_o    <= npa_x_i;
      pkt_y_o    <= npa_y_i;
      pkt_epa_o  <= npa_epa_i;
      pkt_we_o   <= req_we_i;
      pkt_data_o <= req_data_i;
    end
  end

  // credit counter, issue and resp together cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= max_credits_lp;
    end else if (issue & ~resp_v_i) begin
      credit_r <= credit_r - 1'b1;
    end else if (resp_v_i & ~issue) begin
      credit_r <= credit_r + 1'b1;
    end
  end

  assign stall_o = credit_r == '0;

  // requester honours stall
  a_no_req_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_o |-> !req_v_i)
    else $error("remote_req_ctrl: request while stalled");

  // responses only for requests in flight
  a_no_spurious_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> credit_r != max_credits_lp)
    else $error("remote_req_ctrl: response with nothing outstanding");

endmodule

// ==== hw/remote_req_top.sv ====
//**********************************************************
// remote_req_top
//  - remote request path of one tile
//  - controller plus eva to npa translator
//**********************************************************

`timescale 1ns/1ps

module remote_req_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       cfg_v_i,
  input  manycore_addr_pkg::x_cord_t cfg_tgo_x_i,
  input  manycore_addr_pkg::y_cord_t cfg_tgo_y_i,
  input  logic                       cfg_dram_en_i,
  input  logic                       req_v_i,
  input  manycore_addr_pkg::eva_t    req_eva_i,
  input  logic                       req_we_i,
  input  manycore_addr_pkg::data_t   req_data_i,
  input  logic                       resp_v_i,
  output logic                       pkt_v_o,
  output manycore_addr_pkg::x_cord_t pkt_x_o,
  output manycore_addr_pkg::y_cord_t pkt_y_o,
  output manycore_addr_pkg::epa_t    pkt_epa_o,
  output logic                       pkt_we_o,
  output manycore_addr_pkg::data_t   pkt_data_o,
  output logic                       err_v_o,
  output logic                       stall_o
);

  manycore_addr_pkg::eva_t    eva;
  manycore_addr_pkg::x_cord_t tgo_x;
  manycore_addr_pkg::y_cord_t tgo_y;
  logic                       dram_en;
  manycore_addr_pkg::x_cord_t npa_x;   // combinational npa
  manycore_addr_pkg::y_cord_t npa_y;
  manycore_addr_pkg::epa_t    npa_epa;
  logic                       npa_invalid;

  remote_req_ctrl ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cfg_v_i       (cfg_v_i),
    .cfg_tgo_x_i   (cfg_tgo_x_i),
    .cfg_tgo_y_i   (cfg_tgo_y_i),
    .cfg_dram_en_i (cfg_dram_en_i),
    .req_v_i       (req_v_i),
    .req_eva_i     (req_eva_i),
    .req_we_i      (req_we_i),
    .req_data_i    (req_data_i),
    .resp_v_i      (resp_v_i),
    .eva_o         (eva),
    .tgo_x_o       (tgo_x),
    .tgo_y_o       (tgo_y),
    .dram_en_o     (dram_en),
    .npa_x_i       (npa_x),
    .npa_y_i       (npa_y),
    .npa_epa_i     (npa_epa),
    .npa_invalid_i (npa_invalid),
    .pkt_v_o       (pkt_v_o),
    .pkt_x_o       (pkt_x_o),
    .pkt_y_o       (pkt_y_o),
    .pkt_epa_o     (pkt_epa_o),
    .pkt_we_o      (pkt_we_o),
    .pkt_data_o    (pkt_data_o),
    .err_v_o       (err_v_o),
    .stall_o       (stall_o)
  );

  eva_to_npa xlate (
    .eva_i             (eva),
    .tgo_x_i           (tgo_x),
    .tgo_y_i           (tgo_y),
    .dram_enable_i     (dram_en),
    .x_cord_o          (npa_x),
    .y_cord_o          (npa_y),
    .epa_o             (npa_epa),
    .is_invalid_addr_o (npa_invalid)
  );

endmodule

// ==== tests/remote_req_model.svh ====
//************************************************************
// reference model for the remote request path
//  - eva class decode by prefix priority
//  - npa translation per class, dram bank xor fold
//************************************************************

`ifndef REMOTE_REQ_MODEL_SVH
`define REMOTE_REQ_MODEL_SVH

// returns 1 for an invalid eva, else fills x, y and epa
function automatic logic model_xlate(input logic [31:0] eva, input int ox, input int oy,
                                     input logic dram_on, output logic [3:0] x,
                                     output logic [3:0] y, output logic [15:0] epa);
  logic [2:0] bank;
  bank = eva[7:5] ^ eva[10:8]; // block = eva[30:5], fold bits 2:0 with 5:3
  x    = 4'd0;
  y    = 4'd0;
  epa  = 16'd0;
  if (eva[31] && dram_on) begin
    x   = {2'b00, bank[1:0]};
    y   = bank[2] ? 4'd15 : 4'd0;
    epa = {1'b0, eva[19:8], eva[4:2]}; // set index is block bits 14:3
  end else if (eva[31] && eva[30]) begin
    y   = 4'd1;                        // host memory
    epa = {1'b1, eva[16:2]};
  end else if (eva[31]) begin
    x   = {2'b00, eva[13:12]};         // vcache as block memory
    y   = eva[14] ? 4'd15 : 4'd0;
    epa = {6'd0, eva[11:2]};
  end else if (eva[30]) begin          // global, 6-bit fields cut to 4
    y   = eva[27:24];
    x   = eva[21:18];
    epa = eva[17:2];
  end else if (eva[29]) begin          // tile-group
    y   = 4'((int'(eva[28:24]) + oy) % 16);
    x   = 4'((int'(eva[23:18]) + ox) % 16);
    epa = eva[17:2];
  end else if (eva[28:27] == 2'b01) begin // shared
    y   = 4'((int'(eva[5:4]) + oy) % 16);
    x   = 4'((int'(eva[3:2]) + ox) % 16);
    epa = 16'((int'(eva[26:6]) + 'h1000) % 65536);
  end else begin
    return 1'b1;
  end
  return 1'b0;
endfunction

`endif

// ==== tests/tb_remote_req.sv ====
//************************************************************
// testbench for remote_req_top
//  - clock, reset, random requests, config and responses
//  - scoreboard against the reference model, credit tracking
//  - watchdog
//************************************************************

`timescale 1ns/1ps

module tb_remote_req;

  `include "remote_req_model.svh"

  localparam int num_req_lp  = 2000;
  localparam int period_lp   = 100; // ns
  localparam int max_cred_lp = manycore_addr_pkg::max_out_credits_gp;

  logic clk = 1'b0;
  logic reset, cfg_v, cfg_dram_en, req_v, req_we, resp_v;
  logic [3:0] cfg_tgo_x, cfg_tgo_y;
  logic [31:0] req_eva, req_data;
  logic pkt_v, pkt_we, err_v, stall;
  logic [3:0] pkt_x, pkt_y;
  logic [15:0] pkt_epa;
  logic [31:0] pkt_data;

  integer seed;
  int m_ox, m_oy, credits, req_cnt; // shadow config and credits
  logic m_dram;
  logic exp_pkt, exp_err, exp_stall, exp_we;
  logic [3:0] exp_x, exp_y;
  logic [15:0] exp_epa;
  logic [31:0] exp_data;
  int err_strobe, err_field, err_stall;

  remote_req_top dut (
    .clk_i(clk), .reset_i(reset), .cfg_v_i(cfg_v), .cfg_tgo_x_i(cfg_tgo_x),
    .cfg_tgo_y_i(cfg_tgo_y), .cfg_dram_en_i(cfg_dram_en), .req_v_i(req_v),
    .req_eva_i(req_eva), .req_we_i(req_we), .req_data_i(req_data), .resp_v_i(resp_v),
    .pkt_v_o(pkt_v), .pkt_x_o(pkt_x), .pkt_y_o(pkt_y), .pkt_epa_o(pkt_epa),
    .pkt_we_o(pkt_we), .pkt_data_o(pkt_data), .err_v_o(err_v), .stall_o(stall)
  );

  always #(period_lp / 2) clk = ~clk;

  // inputs still hold last cycle's drive, dut samples them at this edge
  task automatic predict();
    logic bad;
    exp_pkt = 1'b0;
    exp_err = 1'b0;
    if (req_v) begin
      bad      = model_xlate(req_eva, m_ox, m_oy, m_dram, exp_x, exp_y, exp_epa);
      exp_pkt  = !bad;
      exp_err  = bad;   // dropped, no credit
      exp_we   = req_we;
      exp_data = req_data;
    end
    if (exp_pkt && !resp_v) credits--;
    else if (resp_v && !exp_pkt) credits++;
    exp_stall = credits == 0;
    if (cfg_v) begin    // visible to later requests only
      m_ox   = cfg_tgo_x;
      m_oy   = cfg_tgo_y;
      m_dram = cfg_dram_en;
    end
  endtask

  task automatic drive(input logic active);
    logic [31:0] r;
    logic [31:0] eva;
    logic        do_req;
    r   = $random(seed);
    eva = $random(seed);
    case (r[2:0])
      3'd0, 3'd1: eva[31] = 1'b1;       // dram
      3'd2: eva[31:30] = 2'b01;         // global
      3'd3: eva[31:29] = 3'b001;        // tile-group
      3'd4: eva[31:27] = 5'b00001;      // shared
      3'd5: eva[31:27] = 5'b00000;      // always invalid
      default: ;                        // raw
    endcase
    do_req = active && credits != 0 && r[4:3] != 2'b00;
    if (do_req) req_cnt++;
    req_v       <= do_req;
    req_eva     <= eva;
    req_we      <= r[5];
    req_data    <= $random(seed);
    resp_v      <= active && credits != max_cred_lp && r[6];
    cfg_v       <= active && r[11:8] == 4'h0; // rare origin / mode change
    cfg_tgo_x   <= r[15:12];
    cfg_tgo_y   <= r[19:16];
    cfg_dram_en <= r[20];
  endtask

  task automatic check();
    assert (pkt_v === exp_pkt && err_v === exp_err) else begin
      err_strobe++;
      $display("Error at %0t ns: pkt_v %b err_v %b, expected %b %b",
               $time, pkt_v, err_v, exp_pkt, exp_err);
    end
    assert (stall === exp_stall) else begin
      err_stall++;
      $display("Error at %0t ns: stall %b, expected %b with %0d credits",
               $time, stall, exp_stall, credits);
    end
    if (exp_pkt) begin
      assert ({pkt_x, pkt_y, pkt_epa, pkt_we, pkt_data} ===
              {exp_x, exp_y, exp_epa, exp_we, exp_data}) else begin
        err_field++;
        $display("Error at %0t ns: pkt x %h y %h epa %h, expected x %h y %h epa %h",
                 $time, pkt_x, pkt_y, pkt_epa, exp_x, exp_y, exp_epa);
      end
    end
  endtask

  task automatic run_cycle(input logic active);
    @(posedge clk);
    predict();
    drive(active);
    @(negedge clk); // outputs settled
    check();
  endtask

  initial begin
    seed        = 32'h32962cd6;
    reset       = 1'b1;
    cfg_v       = 1'b0;
    cfg_tgo_x   = 4'd0;
    cfg_tgo_y   = 4'd0;
    cfg_dram_en = 1'b0;
    req_v       = 1'b0;
    req_eva     = 32'd0;
    req_we      = 1'b0;
    req_data    = 32'd0;
    resp_v      = 1'b0;
    m_ox        = 0;
    m_oy        = 0;
    m_dram      = 1'b0;
    credits     = max_cred_lp;
    req_cnt     = 0;
    err_strobe  = 0;
    err_field   = 0;
    err_stall   = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    while (req_cnt < num_req_lp) run_cycle(1'b1);
    run_cycle(1'b0); // last request still in flight
    $display("%0d requests, errors: strobe %0d, field %0d, stall %0d",
             req_cnt, err_strobe, err_field, err_stall);
    if (err_strobe + err_field + err_stall == 0) $display("SIMULATION PASSED");
    else $display("SIMULATION FAILED");
    $finish;
  end

  // four cycles per request is far beyond the worst credit stall
  initial begin
    #(num_req_lp * 4 * period_lp);
    $display("watchdog expired before all %0d requests were checked", num_req_lp);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+tests
hw/manycore_addr_pkg.sv
hw/dram_hash.sv
hw/eva_to_npa.sv
hw/remote_req_ctrl.sv
hw/remote_req_top.sv
tests/tb_remote_req.sv

// ==== Makefile ====
# Verilator build and run for the remote request path

TOP = tb_remote_req

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless the pass message appears"
	@echo "  clean  remove the Verilator build directory"

obj_dir/V$(TOP): vlog.f hw/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
